/* design/audio_pkg.sv */
package audio_pkg;

  // Stored samples are 16-bit two's complement
  typedef logic signed [15:0] sample_t;

  // Output samples keep only the upper byte
  typedef logic signed [7:0] audio_out_t;

  // Word address into the flash, one word is 32 bits
  typedef logic [22:0] flash_addr_t;

  // Two samples packed per flash word
  typedef struct packed {
    sample_t sample_hi;
    sample_t sample_lo;
  } sample_pair_t;

  // The bus moves raw words, the unpacker reads them as a pair
  typedef union packed {
    logic [31:0]  raw;
    sample_pair_t pair;
  } flash_word_u;

  // Wishbone classic read, master side
  typedef struct packed {
    logic        cyc;
    logic        stb;
    flash_addr_t adr;
  } wb_req_t;

  // Wishbone classic read, slave side
  typedef struct packed {
    logic        ack;
    flash_word_u dat;
  } wb_rsp_t;

endpackage

/* design/control_pkg.sv */
package control_pkg;

  // Play control bits, also shown on LEDs
  typedef struct packed {
    logic playing;
    logic forward;
    logic restart;
  } play_state_t;

  localparam play_state_t PLAY_STATE_INIT = '{playing: 1'b0, forward: 1'b1, restart: 1'b0};

  // ASCII key codes
  typedef logic [7:0] key_code_t;

  localparam key_code_t KEY_PLAY    = 8'h45;
  localparam key_code_t KEY_PAUSE   = 8'h44;
  localparam key_code_t KEY_FWD     = 8'h46;
  localparam key_code_t KEY_BWD     = 8'h42;
  localparam key_code_t KEY_RESTART = 8'h52;

  // Lowercase range and the bit that separates the two cases
  localparam key_code_t KEY_LOWER_A  = 8'h61;
  localparam key_code_t KEY_LOWER_Z  = 8'h7A;
  localparam key_code_t KEY_CASE_BIT = 8'h20;

  // Decoded commands
  typedef logic [2:0] cmd_t;

  localparam cmd_t CMD_NONE    = 3'd0;
  localparam cmd_t CMD_PLAY    = 3'd1;
  localparam cmd_t CMD_PAUSE   = 3'd2;
  localparam cmd_t CMD_FWD     = 3'd3;
  localparam cmd_t CMD_BWD     = 3'd4;
  localparam cmd_t CMD_RESTART = 3'd5;

  // Sample clock divisor in CLK_50M cycles
  typedef logic [15:0] divisor_t;

  // Segments g..a, active low
  typedef logic [6:0] seg7_t;

  // Digit 0 is the least significant nibble
  typedef seg7_t [5:0] hex_digits_t;

  function automatic seg7_t seg7_encode(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

endpackage

/* design/kbd_command_decoder.sv */
`timescale 1ns/1ps

module kbd_command_decoder (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  control_pkg::key_code_t   key_code,
  input  logic                     key_valid,
  output control_pkg::play_state_t play_state
);

  import control_pkg::*;

  key_code_t key_upper;
  cmd_t      cmd;

  // Lowercase letters fold onto their uppercase codes
  always_comb
  begin
    if (key_code >= KEY_LOWER_A && key_code <= KEY_LOWER_Z)
      key_upper = key_code & ~KEY_CASE_BIT;
    else
      key_upper = key_code;
  end

  always_comb
  begin
    case (key_upper)
      KEY_PLAY:    cmd = CMD_PLAY;
      KEY_PAUSE:   cmd = CMD_PAUSE;
      KEY_FWD:     cmd = CMD_FWD;
      KEY_BWD:     cmd = CMD_BWD;
      KEY_RESTART: cmd = CMD_RESTART;
      default:     cmd = CMD_NONE;
    endcase
  end

  // Restart is a single-cycle pulse, the other bits are levels
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      play_state <= PLAY_STATE_INIT;
    else
    begin
      play_state.restart <= 1'b0;
      if (key_valid)
      begin
        case (cmd)
          CMD_PLAY:    play_state.playing <= 1'b1;
          CMD_PAUSE:   play_state.playing <= 1'b0;
          CMD_FWD:     play_state.forward <= 1'b1;
          CMD_BWD:     play_state.forward <= 1'b0;
          CMD_RESTART: play_state.restart <= 1'b1;
          default:     ;
        endcase
      end
    end
  end

endmodule

/* design/sample_rate_gen.sv */
`timescale 1ns/1ps

module sample_rate_gen #(
  parameter control_pkg::divisor_t DIV_DEFAULT   = 16'd612,
  parameter control_pkg::divisor_t DIV_STEP      = 16'd2,
  parameter control_pkg::divisor_t DIV_MIN       = 16'd16,
  parameter control_pkg::divisor_t DIV_MAX       = 16'd2000,
  parameter int                    REPEAT_CYCLES = 5000000
) (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  playing,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  output control_pkg::divisor_t divisor,
  output logic                  tick
);

  import control_pkg::*;

  localparam int               REP_W    = $clog2(REPEAT_CYCLES);
  localparam logic [REP_W-1:0] REP_LAST = REP_W'(REPEAT_CYCLES - 1);

  logic [REP_W-1:0] rep_cnt;
  logic             step_up;
  logic             step_down;
  logic             step_due;
  divisor_t         tick_cnt;

  // Both keys together cancel out
  assign step_up   = speed_up & ~speed_down;
  assign step_down = speed_down & ~speed_up;
  assign step_due  = (rep_cnt == REP_LAST);

  // ====================================================================
  // Divisor register with key repeat
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst || speed_reset)
    begin
      divisor <= DIV_DEFAULT;
      rep_cnt <= '0;
    end
    else if (step_up || step_down)
    begin
      if (step_due)
      begin
        rep_cnt <= '0;
        // Smaller divisor means faster playback
        if (step_up)
          divisor <= (divisor <= DIV_MIN + DIV_STEP) ? DIV_MIN : divisor - DIV_STEP;
        else
          divisor <= (divisor >= DIV_MAX - DIV_STEP) ? DIV_MAX : divisor + DIV_STEP;
      end
      else
        rep_cnt <= rep_cnt + 1'b1;
    end
    else
      rep_cnt <= '0;
  end

  // ====================================================================
  // Sample tick, one pulse every divisor cycles
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      tick     <= 1'b0;
      tick_cnt <= DIV_DEFAULT - 16'd1;
    end
    else if (!playing)
    begin
      // Parked at reload so play starts a full period later
      tick     <= 1'b0;
      tick_cnt <= divisor - 16'd1;
    end
    else if (tick_cnt == '0)
    begin
      tick     <= 1'b1;
      tick_cnt <= divisor - 16'd1;
    end
    else
    begin
      tick     <= 1'b0;
      tick_cnt <= tick_cnt - 16'd1;
    end
  end

endmodule

/* design/flash_read_sequencer.sv */
`timescale 1ns/1ps

module flash_read_sequencer #(
  parameter audio_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  control_pkg::play_state_t play_state,
  input  logic                     tick,
  output audio_pkg::wb_req_t       wb_req,
  input  audio_pkg::wb_rsp_t       wb_rsp,
  output audio_pkg::audio_out_t    audio_sample,
  output logic                     sample_strobe
);

  import audio_pkg::*;

  flash_addr_t cur_adr;    // last word fetched
  flash_addr_t fetch_adr;
  logic        fresh;      // next fetch uses cur_adr as is
  logic        half_q;     // second half of word_q still to play
  logic        pending;
  logic        drop;       // in-flight word belongs to before a restart
  logic        word_fwd;
  flash_word_u word_q;

  function automatic audio_out_t upper_byte(input sample_t s);
    return s[15:8];
  endfunction

  // Step one word with wrap at both ends
  always_comb
  begin
    if (fresh)
      fetch_adr = cur_adr;
    else if (play_state.forward)
      fetch_adr = (cur_adr == LAST_ADDR) ? '0 : cur_adr + 1'b1;
    else
      fetch_adr = (cur_adr == '0) ? LAST_ADDR : cur_adr - 1'b1;
  end

  // ====================================================================
  // Wishbone read and sample output
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      wb_req.cyc    <= 1'b0;
      wb_req.stb    <= 1'b0;
      cur_adr       <= '0;
      fresh         <= 1'b1;
      half_q        <= 1'b0;
      pending       <= 1'b0;
      drop          <= 1'b0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= 1'b0;
      if (wb_req.cyc)
      begin
        if (wb_rsp.ack)
        begin
          wb_req.cyc <= 1'b0;
          wb_req.stb <= 1'b0;
          drop       <= 1'b0;
          if (!drop && !play_state.restart)
          begin
            // Forward plays low half first, backward high half first
            word_q        <= wb_rsp.dat;
            word_fwd      <= play_state.forward;
            audio_sample  <= play_state.forward ? upper_byte(wb_rsp.dat.pair.sample_lo)
                                                : upper_byte(wb_rsp.dat.pair.sample_hi);
            sample_strobe <= 1'b1;
            half_q        <= 1'b1;
          end
        end
        else if (play_state.restart)
          drop <= 1'b1;
        // Only one tick is held while the bus is busy
        if (tick && play_state.playing)
          pending <= 1'b1;
      end
      else if (!play_state.playing)
        pending <= 1'b0;
      else if ((tick || pending) && !play_state.restart)
      begin
        pending <= 1'b0;
        if (half_q)
        begin
          audio_sample  <= word_fwd ? upper_byte(word_q.pair.sample_hi)
                                    : upper_byte(word_q.pair.sample_lo);
          sample_strobe <= 1'b1;
          half_q        <= 1'b0;
        end
        else
        begin
          wb_req.cyc <= 1'b1;
          wb_req.stb <= 1'b1;
          wb_req.adr <= fetch_adr;
          cur_adr    <= fetch_adr;
          fresh      <= 1'b0;
        end
      end
      else if (tick)
        pending <= 1'b1;

      // Restart jumps to the start of the current direction
      if (play_state.restart)
      begin
        cur_adr <= play_state.forward ? '0 : LAST_ADDR;
        fresh   <= 1'b1;
        half_q  <= 1'b0;
      end
    end
  end

endmodule

/* design/divisor_hex_display.sv */
`timescale 1ns/1ps

module divisor_hex_display #(
  parameter control_pkg::divisor_t DIV_DEFAULT    = 16'd612,
  parameter int                    REFRESH_CYCLES = 25000000
) (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  control_pkg::divisor_t    divisor,
  output control_pkg::hex_digits_t hex
);

  import control_pkg::*;

  localparam int               CNT_W        = $clog2(REFRESH_CYCLES);
  localparam logic [CNT_W-1:0] REFRESH_LAST = CNT_W'(REFRESH_CYCLES - 1);

  logic [CNT_W-1:0] refresh_cnt;
  logic [23:0]      shown;

  // Slow snapshot keeps the digits readable while keys are held
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      refresh_cnt <= '0;
      shown       <= {8'h00, DIV_DEFAULT};
    end
    else if (refresh_cnt == REFRESH_LAST)
    begin
      refresh_cnt <= '0;
      shown       <= {8'h00, divisor};
    end
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  // One nibble per digit, digit 0 on the right
  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < 6; i++)
    begin
      hex[i] <= seg7_encode(shown[i*4 +: 4]);
    end
  end

endmodule

/* design/simple_ipod_top.sv */
`timescale 1ns/1ps

module simple_ipod_top #(
  parameter control_pkg::divisor_t  DIV_DEFAULT    = 16'd612,
  parameter control_pkg::divisor_t  DIV_STEP       = 16'd2,
  parameter control_pkg::divisor_t  DIV_MIN        = 16'd16,
  parameter control_pkg::divisor_t  DIV_MAX        = 16'd2000,
  parameter int                     REPEAT_CYCLES  = 5000000,
  parameter audio_pkg::flash_addr_t LAST_ADDR      = 23'h7FFFF,
  parameter int                     REFRESH_CYCLES = 25000000
) (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  control_pkg::key_code_t   key_code,
  input  logic                     key_valid,
  input  logic                     speed_up,
  input  logic                     speed_down,
  input  logic                     speed_reset,
  output audio_pkg::wb_req_t       wb_req,
  input  audio_pkg::wb_rsp_t       wb_rsp,
  output audio_pkg::audio_out_t    audio_sample,
  output logic                     sample_strobe,
  output control_pkg::play_state_t play_state,
  output control_pkg::hex_digits_t hex
);

  import control_pkg::*;

  divisor_t divisor;
  logic     tick;

  // ====================================================================
  // Command decode, rate tick, read sequencer, display
  // ====================================================================
  kbd_command_decoder u_kbd_command_decoder (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .key_code   (key_code),
    .key_valid  (key_valid),
    .play_state (play_state)
  );

  sample_rate_gen #(
    .DIV_DEFAULT   (DIV_DEFAULT),
    .DIV_STEP      (DIV_STEP),
    .DIV_MIN       (DIV_MIN),
    .DIV_MAX       (DIV_MAX),
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) u_sample_rate_gen (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .playing     (play_state.playing),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divisor     (divisor),
    .tick        (tick)
  );

  flash_read_sequencer #(
    .LAST_ADDR (LAST_ADDR)
  ) u_flash_read_sequencer (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .play_state    (play_state),
    .tick          (tick),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe)
  );

  divisor_hex_display #(
    .DIV_DEFAULT    (DIV_DEFAULT),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_divisor_hex_display (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .divisor (divisor),
    .hex     (hex)
  );

endmodule

/* bench/ipod_checker.sv */
`timescale 1ns/1ps

module ipod_checker #(
  parameter control_pkg::divisor_t  DIV_DEFAULT    = 16'd40,
  parameter control_pkg::divisor_t  DIV_STEP       = 16'd2,
  parameter control_pkg::divisor_t  DIV_MIN        = 16'd16,
  parameter control_pkg::divisor_t  DIV_MAX        = 16'd2000,
  parameter audio_pkg::flash_addr_t LAST_ADDR      = 23'd15,
  parameter int                     REFRESH_CYCLES = 64
) (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  control_pkg::key_code_t   key_code,
  input  logic                     key_valid,
  input  logic                     speed_up,
  input  logic                     speed_down,
  input  logic                     speed_reset,
  input  audio_pkg::wb_req_t       wb_req,
  input  audio_pkg::wb_rsp_t       wb_rsp,
  input  audio_pkg::audio_out_t    audio_sample,
  input  logic                     sample_strobe,
  input  control_pkg::play_state_t play_state,
  input  control_pkg::hex_digits_t hex,
  output int                       value_errors,
  output int                       other_errors,
  output int                       fwd_wraps,
  output int                       bwd_wraps,
  output int                       second_strobes
);

  import audio_pkg::*;
  import control_pkg::*;

  play_state_t exp_state;
  logic        prev_playing;
  logic        prev_forward;
  logic        prev_cyc;
  logic        prev_ack;
  flash_addr_t prev_adr;
  flash_addr_t last_adr;
  flash_addr_t fresh_adr;
  logic        fresh;
  logic        first_due;
  logic        second_due;
  logic [7:0]  exp_first;
  logic [7:0]  exp_second;
  logic        rise_valid;
  logic        rise_clean;
  int          rise_time;
  int          now;
  logic        speed_dirty;
  int          refresh_wait;

  // Word the flash model returns for each address
  function automatic logic [31:0] expected_word(input flash_addr_t a);
    return {1'b1, a[6:0], a[14:7], 1'b0, a[6:0], a[22:15]};
  endfunction

  function automatic key_code_t fold_case(input key_code_t k);
    if (k >= 8'h61 && k <= 8'h7A)
      return k - 8'h20;
    return k;
  endfunction

  // Addresses run modulo LAST_ADDR + 1 in either direction
  function automatic flash_addr_t next_adr(input flash_addr_t a, input logic fwd);
    int span;
    span = LAST_ADDR + 1;
    if (fwd)
      return flash_addr_t'((a + 1) % span);
    return flash_addr_t'((a + span - 1) % span);
  endfunction

  // Bit 4 flags a pattern that is no hex digit
  function automatic logic [4:0] seg_to_nibble(input seg7_t s);
    case (s)
      7'b1000000: return 5'h00;
      7'b1111001: return 5'h01;
      7'b0100100: return 5'h02;
      7'b0110000: return 5'h03;
      7'b0011001: return 5'h04;
      7'b0010010: return 5'h05;
      7'b0000010: return 5'h06;
      7'b1111000: return 5'h07;
      7'b0000000: return 5'h08;
      7'b0010000: return 5'h09;
      7'b0001000: return 5'h0A;
      7'b0000011: return 5'h0B;
      7'b1000110: return 5'h0C;
      7'b0100001: return 5'h0D;
      7'b0000110: return 5'h0E;
      7'b0001110: return 5'h0F;
      default:    return 5'h10;
    endcase
  endfunction

  function automatic logic reachable(input int v);
    if (v < DIV_MIN || v > DIV_MAX)
      return 1'b0;
    if (v >= DIV_DEFAULT)
      return ((v - DIV_DEFAULT) % DIV_STEP == 0) || (v == DIV_MAX);
    return ((DIV_DEFAULT - v) % DIV_STEP == 0) || (v == DIV_MIN);
  endfunction

  // ======================================================================
  // Port checks on the falling edge
  // ======================================================================
  always @(negedge CLK_50M)
  begin
    logic [31:0] w;
    logic [4:0]  nib;
    logic        bad_digit;
    int          hv;
    int          gap;
    flash_addr_t e;

    now = now + 1;
    if (rst)
    begin
      exp_state    = '{playing: 1'b0, forward: 1'b1, restart: 1'b0};
      prev_playing = 1'b0;
      prev_forward = 1'b1;
      prev_cyc     = 1'b0;
      prev_ack     = 1'b0;
      prev_adr     = '0;
      last_adr     = '0;
      fresh_adr    = '0;
      fresh        = 1'b1;
      first_due    = 1'b0;
      second_due   = 1'b0;
      rise_valid   = 1'b0;
      rise_clean   = 1'b0;
      speed_dirty  = 1'b0;
      refresh_wait = 3;
      if (wb_req.cyc !== 1'b0 || sample_strobe !== 1'b0)
      begin
        other_errors++;
        $display("Bus cycle or sample strobe active during reset");
      end
    end
    else
    begin
      if (play_state !== exp_state)
      begin
        value_errors++;
        $display("Error: play_state expected 0x%h got 0x%h", exp_state, play_state);
      end

      // Restart points the next fetch at the start of the current direction
      if (exp_state.restart)
      begin
        fresh      = 1'b1;
        fresh_adr  = exp_state.forward ? '0 : LAST_ADDR;
        second_due = 1'b0;
        rise_valid = 1'b0;
      end
      exp_state.restart = 1'b0;
      if (key_valid)
      begin
        case (fold_case(key_code))
          8'h45:   exp_state.playing = 1'b1;
          8'h44:   exp_state.playing = 1'b0;
          8'h46:   exp_state.forward = 1'b1;
          8'h42:   exp_state.forward = 1'b0;
          8'h52:   exp_state.restart = 1'b1;
          default: ;
        endcase
      end

      if (wb_req.cyc !== wb_req.stb)
      begin
        other_errors++;
        $display("Wishbone cyc and stb differ");
      end

      if (wb_req.cyc && !prev_cyc)
      begin
        if (!prev_playing)
        begin
          other_errors++;
          $display("Bus cycle started while paused");
        end
        e = fresh ? fresh_adr : next_adr(last_adr, prev_forward);
        if (wb_req.adr !== e)
        begin
          value_errors++;
          $display("Error: wb_req.adr expected 0x%h got 0x%h", e, wb_req.adr);
        end
        if (!fresh && last_adr == LAST_ADDR && wb_req.adr == '0 && prev_forward)
          fwd_wraps++;
        if (!fresh && last_adr == '0 && wb_req.adr == LAST_ADDR && !prev_forward)
          bwd_wraps++;
        last_adr   = wb_req.adr;
        fresh      = 1'b0;
        rise_time  = now;
        rise_valid = 1'b1;
        rise_clean = !speed_dirty && refresh_wait < REFRESH_CYCLES;
      end
      else if (prev_cyc && wb_req.cyc === prev_ack)
      begin
        other_errors++;
        $display("Bus cycle did not end right after its acknowledge");
      end
      else if (wb_req.cyc && prev_cyc && wb_req.adr !== prev_adr)
      begin
        other_errors++;
        $display("Address changed before the slave acknowledged");
      end

      if (sample_strobe)
      begin
        if (first_due)
        begin
          if (audio_sample !== exp_first)
          begin
            value_errors++;
            $display("Error: audio_sample expected 0x%h got 0x%h", exp_first, audio_sample);
          end
          first_due  = 1'b0;
          second_due = 1'b1;
        end
        else if (second_due)
        begin
          if (!prev_playing)
          begin
            other_errors++;
            $display("Second half played while paused");
          end
          if (audio_sample !== exp_second)
          begin
            value_errors++;
            $display("Error: audio_sample expected 0x%h got 0x%h", exp_second, audio_sample);
          end
          // Second half comes one divisor after the fetch
          gap = now - rise_time;
          if (rise_valid && rise_clean && gap != DIV_DEFAULT)
          begin
            value_errors++;
            $display("Error: tick spacing expected 0x%h got 0x%h", DIV_DEFAULT, gap);
          end
          else if (rise_valid && !reachable(gap))
          begin
            value_errors++;
            $display("Error: tick spacing 0x%h is no reachable divisor", gap);
          end
          second_due = 1'b0;
          rise_valid = 1'b0;
          second_strobes++;
        end
        else
        begin
          other_errors++;
          $display("Sample strobe without a word to play");
        end
      end
      else if (first_due)
      begin
        other_errors++;
        $display("No sample strobe after the acknowledge");
        first_due = 1'b0;
      end

      if (wb_req.cyc && wb_rsp.ack)
      begin
        w          = expected_word(wb_req.adr);
        exp_first  = play_state.forward ? w[15:8] : w[31:24];
        exp_second = play_state.forward ? w[31:24] : w[15:8];
        first_due  = 1'b1;
      end

      if (!play_state.playing)
        rise_valid = 1'b0;

      // Display
      hv        = 0;
      bad_digit = 1'b0;
      for (int i = 5; i >= 0; i--)
      begin
        nib       = seg_to_nibble(hex[i]);
        bad_digit = bad_digit | nib[4];
        hv        = (hv << 4) | nib[3:0];
      end
      if (bad_digit)
      begin
        other_errors++;
        $display("Display shows a pattern that is no hex digit");
      end
      else if (!reachable(hv))
      begin
        value_errors++;
        $display("Error: hex value 0x%h is no reachable divisor", hv);
      end
      else if (!speed_dirty && refresh_wait == 0 && hv != DIV_DEFAULT)
      begin
        value_errors++;
        $display("Error: hex expected 0x%h got 0x%h", DIV_DEFAULT, hv);
      end

      if (speed_reset)
      begin
        speed_dirty  = 1'b0;
        refresh_wait = REFRESH_CYCLES + 3;
      end
      else
      begin
        if (speed_up || speed_down)
          speed_dirty = 1'b1;
        if (refresh_wait > 0)
          refresh_wait = refresh_wait - 1;
      end

      prev_playing = play_state.playing;
      prev_forward = play_state.forward;
      prev_cyc     = wb_req.cyc;
      prev_ack     = wb_rsp.ack;
      prev_adr     = wb_req.adr;
    end
  end

  initial
  begin
    value_errors   = 0;
    other_errors   = 0;
    fwd_wraps      = 0;
    bwd_wraps      = 0;
    second_strobes = 0;
    now            = 0;
    rise_time      = 0;
  end

endmodule

/* bench/tb_simple_ipod.sv */
`timescale 1ns/1ps

module tb_simple_ipod;

  import audio_pkg::*;
  import control_pkg::*;

  localparam divisor_t    DIV_DEFAULT    = 16'd40;
  localparam divisor_t    DIV_STEP       = 16'd2;
  localparam divisor_t    DIV_MIN        = 16'd16;
  localparam divisor_t    DIV_MAX        = 16'd2000;
  localparam int          REPEAT_CYCLES  = 32;
  localparam flash_addr_t LAST_ADDR      = 23'd15;
  localparam int          REFRESH_CYCLES = 64;
  localparam int          TIMEOUT_MARGIN = 500;
  localparam int          NUM_ROWS       = 17;

  // Row kinds
  localparam logic [1:0] KIND_IDLE  = 2'd0;
  localparam logic [1:0] KIND_KEY   = 2'd1;
  localparam logic [1:0] KIND_UP    = 2'd2;
  localparam logic [1:0] KIND_RESET = 2'd3;

  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  arg;
    logic [15:0] hold;
  } row_t;

  logic        CLK_50M = 1'b0;
  logic        rst = 1'b1;
  key_code_t   key_code = '0;
  logic        key_valid = 1'b0;
  logic        speed_up = 1'b0;
  logic        speed_down = 1'b0;
  logic        speed_reset = 1'b0;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp = '0;
  audio_out_t  audio_sample;
  logic        sample_strobe;
  play_state_t play_state;
  hex_digits_t hex;

  row_t   rows [NUM_ROWS];
  integer seed = 3832;
  int     wait_left;
  int     wait_pick;
  logic   busy;
  int     cycle_count = 0;
  int     timeout_limit = 1000000;
  int     total_hold;
  int     coverage_errors;
  int     value_errors;
  int     other_errors;
  int     fwd_wraps;
  int     bwd_wraps;
  int     second_strobes;

  simple_ipod_top #(
    .DIV_DEFAULT    (DIV_DEFAULT),
    .DIV_STEP       (DIV_STEP),
    .DIV_MIN        (DIV_MIN),
    .DIV_MAX        (DIV_MAX),
    .REPEAT_CYCLES  (REPEAT_CYCLES),
    .LAST_ADDR      (LAST_ADDR),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_simple_ipod_top (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .key_code      (key_code),
    .key_valid     (key_valid),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe),
    .play_state    (play_state),
    .hex           (hex)
  );

  ipod_checker #(
    .DIV_DEFAULT    (DIV_DEFAULT),
    .DIV_STEP       (DIV_STEP),
    .DIV_MIN        (DIV_MIN),
    .DIV_MAX        (DIV_MAX),
    .LAST_ADDR      (LAST_ADDR),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_ipod_checker (
    .CLK_50M        (CLK_50M),
    .rst            (rst),
    .key_code       (key_code),
    .key_valid      (key_valid),
    .speed_up       (speed_up),
    .speed_down     (speed_down),
    .speed_reset    (speed_reset),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .audio_sample   (audio_sample),
    .sample_strobe  (sample_strobe),
    .play_state     (play_state),
    .hex            (hex),
    .value_errors   (value_errors),
    .other_errors   (other_errors),
    .fwd_wraps      (fwd_wraps),
    .bwd_wraps      (bwd_wraps),
    .second_strobes (second_strobes)
  );

  initial
  begin
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Upper bytes 1xxxxxxx and 0xxxxxxx tell the two halves apart
  function automatic logic [31:0] flash_word_at(input flash_addr_t a);
    return {1'b1, a[6:0], a[14:7], 1'b0, a[6:0], a[22:15]};
  endfunction

  // ======================================================================
  // Flash slave with 0 to 3 wait cycles
  // ======================================================================
  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      wb_rsp.ack <= 1'b0;
      busy       <= 1'b0;
      wait_left  <= 0;
    end
    else if (wb_rsp.ack)
    begin
      wb_rsp.ack <= 1'b0;
      busy       <= 1'b0;
    end
    else if (wb_req.cyc && wb_req.stb)
    begin
      if (!busy)
      begin
        wait_pick = $random(seed) & 32'h3;
        busy      <= 1'b1;
        wait_left <= wait_pick;
        if (wait_pick == 0)
        begin
          wb_rsp.ack     <= 1'b1;
          wb_rsp.dat.raw <= flash_word_at(wb_req.adr);
        end
      end
      else if (wait_left <= 1)
      begin
        wb_rsp.ack     <= 1'b1;
        wb_rsp.dat.raw <= flash_word_at(wb_req.adr);
      end
      else
        wait_left <= wait_left - 1;
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", timeout_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic apply_row(input row_t r);
    case (r.kind)
      KIND_KEY:
      begin
        key_code  <= r.arg;
        key_valid <= 1'b1;
        @(posedge CLK_50M);
        key_valid <= 1'b0;
        repeat (r.hold - 1) @(posedge CLK_50M);
      end
      KIND_UP:
      begin
        speed_up <= 1'b1;
        repeat (r.hold) @(posedge CLK_50M);
        speed_up <= 1'b0;
      end
      KIND_RESET:
      begin
        speed_reset <= 1'b1;
        repeat (r.hold) @(posedge CLK_50M);
        speed_reset <= 1'b0;
      end
      default:
        repeat (r.hold) @(posedge CLK_50M);
    endcase
  endtask

  task automatic finish_run();
    coverage_errors = 0;
    if (fwd_wraps == 0 || bwd_wraps == 0)
    begin
      coverage_errors++;
      $display("Address wrap not seen in both directions");
    end
    if (second_strobes < 20)
    begin
      coverage_errors++;
      $display("Too few complete words were played");
    end
    $display("Errors: value %0d, other %0d, coverage %0d",
             value_errors, other_errors, coverage_errors);
    if (value_errors + other_errors + coverage_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  // ======================================================================
  // Stimulus table
  // ======================================================================
  initial
  begin
    rows = '{
      '{KIND_IDLE,  8'h00, 16'd120},
      '{KIND_KEY,   8'h45, 16'd5},
      '{KIND_KEY,   8'h46, 16'd1500},
      '{KIND_KEY,   8'h78, 16'd40},
      '{KIND_KEY,   8'h42, 16'd1500},
      '{KIND_KEY,   8'h64, 16'd200},
      '{KIND_KEY,   8'h72, 16'd100},
      '{KIND_KEY,   8'h65, 16'd400},
      '{KIND_KEY,   8'h66, 16'd10},
      '{KIND_KEY,   8'h44, 16'd60},
      '{KIND_KEY,   8'h52, 16'd20},
      '{KIND_KEY,   8'h45, 16'd400},
      '{KIND_UP,    8'h00, 16'd420},
      '{KIND_IDLE,  8'h00, 16'd300},
      '{KIND_RESET, 8'h00, 16'd3},
      '{KIND_IDLE,  8'h00, 16'd300},
      '{KIND_KEY,   8'h44, 16'd100}
    };
    total_hold = 0;
    for (int i = 0; i < NUM_ROWS; i++)
      total_hold += rows[i].hold;
    timeout_limit = total_hold + 24 + TIMEOUT_MARGIN;

    repeat (4) @(posedge CLK_50M);
    rst <= 1'b0;
    for (int i = 0; i < NUM_ROWS; i++)
      apply_row(rows[i]);
    repeat (20) @(posedge CLK_50M);
    finish_run();
  end

endmodule

/* project.f */
design/audio_pkg.sv
design/control_pkg.sv
design/kbd_command_decoder.sv
design/sample_rate_gen.sv
design/flash_read_sequencer.sv
design/divisor_hex_display.sv
design/simple_ipod_top.sv
bench/ipod_checker.sv
bench/tb_simple_ipod.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_simple_ipod \
  -f project.f -o sim_ipod \
  && ./obj_dir/sim_ipod > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation reported failure"; exit 1; } \
  || { grep -q ">>> PASS" sim.log || { echo "No result line in log"; exit 1; }; }
exit 0
